// File: bench/tb_packet_dealer.sv
module tb_packet_dealer;

  timeunit 1ns;
  timeprecision 1ps;

  import pd_pkg::*;

  localparam int NUM_FRAMES = 200;
  localparam int CLK_PERIOD = 8;
  localparam logic [15:0] LFSR_SEED = 16'd23267;
  // Longest frame, eight cycles per byte
  localparam longint TIMEOUT_NS = longint'(NUM_FRAMES) * SLOT_DEPTH * 8 * CLK_PERIOD;

  logic  CLK, RST_N;
  logic  rx_valid, rx_last, rx_ready;
  byte_t rx_data;
  logic  hdr_valid, hdr_ready;
  hdr_t  hdr_data;
  logic  verdict_valid, verdict_pass, verdict_ready;
  logic  tx_valid, tx_last, tx_ready, drop_pulse;
  byte_t tx_data;

  // ------------------------------
  // Model state
  // ------------------------------

  logic [15:0] lfsr = LFSR_SEED;
  byte_t frame_bytes [NUM_FRAMES][SLOT_DEPTH];
  int    frame_len [NUM_FRAMES];
  // Frames stored and waiting for a verdict, then passed frames waiting for tx
  int    rx_done_q [$];
  int    pass_q [$];
  int    frames_rcv, hdrs_seen, verdicts_issued, forwarded, dropped, pending_drops;
  int    err_reset, err_hdr, err_tx, err_drop, err_flow;

  packet_dealer u_dut (.*);

  // Galois LFSR, one step per bit taken
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  // First byte in the top lane, missing bytes stay zero
  function automatic hdr_t build_header(input int f);
    hdr_t h;
    h = '0;
    for (int i = 0; i < HDR_LEN && i < frame_len[f]; i++) begin
      h[(HDR_LEN - 1 - i) * BYTE_W +: BYTE_W] = frame_bytes[f][i];
    end
    return h;
  endfunction

  task automatic show_mismatch(input string sig, input hdr_t exp_val, input hdr_t act_val);
    $display("[FAIL] %s expected %0h got %0h at %0t", sig, exp_val, act_val, $time);
  endtask

  // Output expected low right after reset
  task automatic check_reset_low(input string sig, input logic act);
    if (act !== 1'b0) begin
      show_mismatch(sig, '0, hdr_t'(act));
      err_reset++;
    end
  endtask

  task automatic print_result(input string name, input int errs);
    if (errs == 0) $display("%s: pass", name);
    else $display("%s: fail with %0d errors", name, errs);
  endtask

  initial begin : clock_gen
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, only %0d of %0d frames finished",
             TIMEOUT_NS, forwarded + dropped, NUM_FRAMES);
    $display("TEST FAILED");
    $finish;
  end

  // ------------------------------
  // Reset, source and report
  // ------------------------------

  initial begin : main
    int len, total, failed;
    RST_N = 1'b0;
    rx_valid = 1'b0;
    rx_data = '0;
    rx_last = 1'b0;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    RST_N = 1'b1;
    #1;
    if (rx_ready !== 1'b1) begin
      show_mismatch("rx_ready", hdr_t'(1'b1), hdr_t'(rx_ready));
      err_reset++;
    end
    check_reset_low("hdr_valid", hdr_valid);
    check_reset_low("verdict_ready", verdict_ready);
    check_reset_low("tx_valid", tx_valid);
    check_reset_low("drop_pulse", drop_pulse);
    print_result("reset state", err_reset);
    for (int f = 0; f < NUM_FRAMES; f++) begin
      len = rand_bits(6) + 1;
      frame_len[f] = len;
      for (int i = 0; i < len; i++) frame_bytes[f][i] = byte_t'(rand_bits(8));
      for (int i = 0; i < len; i++) begin
        @(negedge CLK);
        rx_valid = 1'b0;
        // Random idle cycles between bytes
        while (rand_bits(2) == 0) @(negedge CLK);
        rx_valid = 1'b1;
        rx_data = frame_bytes[f][i];
        rx_last = (i == len - 1);
        #1;
        while (!rx_ready) begin
          @(negedge CLK);
          #1;
        end
      end
      rx_done_q.push_back(f);
      frames_rcv++;
    end
    @(negedge CLK);
    rx_valid = 1'b0;
    rx_last = 1'b0;
    while (forwarded + dropped < NUM_FRAMES) @(negedge CLK);
    // A few idle cycles to catch stray pulses
    repeat (8) @(negedge CLK);
    if (hdrs_seen != NUM_FRAMES) begin
      $display("Saw %0d headers for %0d frames", hdrs_seen, NUM_FRAMES);
      err_hdr++;
    end
    if (pass_q.size() != 0) begin
      $display("%0d passed frames never appeared on tx", pass_q.size());
      err_tx++;
    end
    if (pending_drops != 0 || forwarded + dropped != NUM_FRAMES) begin
      $display("Forwarded %0d plus dropped %0d does not add up to %0d frames",
               forwarded, dropped, NUM_FRAMES);
      err_drop++;
    end
    print_result("header content", err_hdr);
    print_result("passed frames", err_tx);
    print_result("dropped frames", err_drop);
    print_result("flow control", err_flow);
    total = err_reset + err_hdr + err_tx + err_drop + err_flow;
    failed = int'(err_reset != 0) + int'(err_hdr != 0) + int'(err_tx != 0) +
             int'(err_drop != 0) + int'(err_flow != 0);
    $display("Tests 5, passed %0d, failed %0d, errors %0d, forwarded %0d, dropped %0d",
             5 - failed, failed, total, forwarded, dropped);
    if (total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // ------------------------------
  // Firewall side
  // ------------------------------

  // Header sink with stalls and hold check
  initial begin : hdr_sink
    hdr_t held;
    logic stalled;
    stalled = 1'b0;
    hdr_ready = 1'b0;
    @(posedge RST_N);
    forever begin
      @(negedge CLK);
      hdr_ready = (rand_bits(2) != 0);
      #1;
      if (stalled && !hdr_valid) begin
        $display("hdr_valid fell before the header was taken at %0t", $time);
        err_flow++;
      end else if (stalled && hdr_data !== held) begin
        show_mismatch("hdr_data", held, hdr_data);
        err_flow++;
      end
      if (hdr_valid && hdr_ready) begin
        if (hdrs_seen >= frames_rcv) begin
          $display("Header offered before its frame was received at %0t", $time);
          err_hdr++;
        end else if (hdr_data !== build_header(hdrs_seen)) begin
          show_mismatch("hdr_data", build_header(hdrs_seen), hdr_data);
          err_hdr++;
        end
        hdrs_seen++;
      end
      stalled = hdr_valid && !hdr_ready;
      held = hdr_data;
    end
  end

  // One verdict per taken header, after a random delay
  initial begin : firewall
    int f;
    verdict_valid = 1'b0;
    verdict_pass = 1'b0;
    @(posedge RST_N);
    forever begin
      @(negedge CLK);
      verdict_valid = 1'b0;
      if (verdicts_issued < hdrs_seen) begin
        repeat (rand_bits(2)) @(negedge CLK);
        verdict_valid = 1'b1;
        verdict_pass = (rand_bits(2) != 0);
        #1;
        while (!verdict_ready) begin
          @(negedge CLK);
          #1;
        end
        if (rx_done_q.size() == 0) begin
          $display("Verdict taken with no stored frame at %0t", $time);
          err_flow++;
        end else begin
          f = rx_done_q.pop_front();
          if (verdict_pass) pass_q.push_back(f);
          else pending_drops++;
        end
        verdicts_issued++;
      end
    end
  end

  // ------------------------------
  // Transmit and drop monitors
  // ------------------------------

  initial begin : tx_sink
    byte_t held_data;
    logic  held_last, stalled;
    int    idx, f;
    stalled = 1'b0;
    idx = 0;
    tx_ready = 1'b0;
    @(posedge RST_N);
    forever begin
      @(negedge CLK);
      tx_ready = (rand_bits(2) != 0);
      #1;
      if (stalled && !tx_valid) begin
        $display("tx_valid fell before the byte was taken at %0t", $time);
        err_flow++;
      end else if (stalled && tx_data !== held_data) begin
        show_mismatch("tx_data", hdr_t'(held_data), hdr_t'(tx_data));
        err_flow++;
      end else if (stalled && tx_last !== held_last) begin
        show_mismatch("tx_last", hdr_t'(held_last), hdr_t'(tx_last));
        err_flow++;
      end
      if (tx_valid && tx_ready) begin
        if (pass_q.size() == 0) begin
          $display("Byte on tx with no passed frame waiting at %0t", $time);
          err_tx++;
        end else begin
          f = pass_q[0];
          if (tx_data !== frame_bytes[f][idx]) begin
            show_mismatch("tx_data", hdr_t'(frame_bytes[f][idx]), hdr_t'(tx_data));
            err_tx++;
          end
          if (tx_last !== (idx == frame_len[f] - 1)) begin
            show_mismatch("tx_last", hdr_t'(idx == frame_len[f] - 1), hdr_t'(tx_last));
            err_tx++;
          end
          // Frame ends on either side's idea of the last byte
          if (tx_last || idx == frame_len[f] - 1) begin
            void'(pass_q.pop_front());
            forwarded++;
            idx = 0;
          end else begin
            idx++;
          end
        end
      end
      stalled = tx_valid && !tx_ready;
      held_data = tx_data;
      held_last = tx_last;
    end
  end

  // Slot occupancy at cycle start, drop pulses mid cycle
  initial begin : flow_monitor
    int occ;
    @(posedge RST_N);
    forever begin
      @(negedge CLK);
      occ = frames_rcv - forwarded - dropped;
      if (occ > NUM_SLOTS) begin
        $display("%0d frames held at once at %0t", occ, $time);
        err_flow++;
      end
      if (occ == NUM_SLOTS && rx_ready !== 1'b0) begin
        show_mismatch("rx_ready", hdr_t'(1'b0), hdr_t'(rx_ready));
        err_flow++;
      end
      #1;
      if (drop_pulse) begin
        if (pending_drops == 0) begin
          $display("drop_pulse with no drop verdict pending at %0t", $time);
          err_drop++;
        end else begin
          pending_drops--;
        end
        dropped++;
      end
    end
  end

endmodule

// File: list.f
rtl/pd_pkg.sv
rtl/pkt_store.sv
rtl/hdr_capture.sv
rtl/verdict_dispatch.sv
rtl/packet_dealer.sv
bench/tb_packet_dealer.sv

// File: rtl/hdr_capture.sv
module hdr_capture (
  input  logic          CLK,
  input  logic          RST_N,
  // Receive stream, observed alongside the store
  input  logic          rx_valid,
  input  pd_pkg::byte_t rx_data,
  input  logic          rx_last,
  input  logic          rx_ready,
  // Low while a header still waits for the firewall
  output logic          hdr_room,
  // Header port
  output logic          hdr_valid,
  output pd_pkg::hdr_t  hdr_data,
  input  logic          hdr_ready
);

  import pd_pkg::*;

  // Collect buffer, bytes land left aligned
  hdr_t     hdr_buf;
  hdr_t     buf_next;
  // Bytes collected so far, stops at HDR_LEN
  hdr_cnt_t cnt;
  logic     rx_fire;
  logic     hdr_full;

  assign rx_fire  = rx_valid && rx_ready;
  assign hdr_full = (cnt == hdr_cnt_t'(HDR_LEN));

  // Only one pending register, so a new frame waits for it to drain
  assign hdr_room = !hdr_valid;

  // ------------------------------
  // Byte placement
  // ------------------------------

  // Byte n goes to byte lane HDR_LEN-1-n, untouched lanes stay zero
  always_comb begin
    buf_next = hdr_buf;
    if (!hdr_full) begin
      buf_next[(HDR_LEN - 1 - int'(cnt)) * BYTE_W +: BYTE_W] = rx_data;
    end
  end

  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      hdr_buf   <= '0;
      cnt       <= '0;
      hdr_valid <= 1'b0;
    end else begin
      if (rx_fire) begin
        if (rx_last) begin
          // Clear for the next frame so short frames pad with zeros
          hdr_buf <= '0;
          cnt     <= '0;
        end else begin
          hdr_buf <= buf_next;
          if (!hdr_full) begin
            cnt <= cnt + hdr_cnt_t'(1);
          end
        end
      end
      // Load on the final byte, header offered on the next cycle
      if (rx_fire && rx_last) begin
        hdr_valid <= 1'b1;
      end else if (hdr_ready) begin
        hdr_valid <= 1'b0;
      end
    end
  end

  // Pending header register
  always_ff @(posedge CLK) begin
    if (rx_fire && rx_last) begin
      hdr_data <= buf_next;
    end
  end

  // Header holds while the firewall stalls
  a_hdr_stable: assert property (
    @(posedge CLK) disable iff (!RST_N)
    (hdr_valid && !hdr_ready) |=> (hdr_valid && $stable(hdr_data))
  );

  // Store gating must keep a frame from ending on top of a pending header
  a_no_overwrite: assert property (
    @(posedge CLK) disable iff (!RST_N)
    (rx_fire && rx_last) |-> !hdr_valid
  );

endmodule

// File: rtl/packet_dealer.sv
module packet_dealer (
  input  logic          CLK,
  input  logic          RST_N,
  // Receive stream
  input  logic          rx_valid,
  input  pd_pkg::byte_t rx_data,
  input  logic          rx_last,
  output logic          rx_ready,
  // Header port to the firewall
  output logic          hdr_valid,
  output pd_pkg::hdr_t  hdr_data,
  input  logic          hdr_ready,
  // Verdict port from the firewall
  input  logic          verdict_valid,
  input  logic          verdict_pass,
  output logic          verdict_ready,
  // Transmit stream
  output logic          tx_valid,
  output pd_pkg::byte_t tx_data,
  output logic          tx_last,
  input  logic          tx_ready,
  output logic          drop_pulse
);

  import pd_pkg::*;

  // Store to dispatcher
  logic       frames_ready;
  frame_len_t head_len;
  byte_t      rd_data;
  // Dispatcher to store
  byte_addr_t rd_addr;
  logic       slot_release;
  // Capture to store
  logic       hdr_room;

  // Frame memory, owns receive flow control
  pkt_store u_store (
    .CLK          (CLK),
    .RST_N        (RST_N),
    .rx_valid     (rx_valid),
    .rx_data      (rx_data),
    .rx_last      (rx_last),
    .rx_ready     (rx_ready),
    .hdr_room     (hdr_room),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .head_len     (head_len),
    .frames_ready (frames_ready),
    .slot_release (slot_release)
  );

  // Sees the same accepted bytes as the store
  hdr_capture u_hdr (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .rx_valid  (rx_valid),
    .rx_data   (rx_data),
    .rx_last   (rx_last),
    .rx_ready  (rx_ready),
    .hdr_room  (hdr_room),
    .hdr_valid (hdr_valid),
    .hdr_data  (hdr_data),
    .hdr_ready (hdr_ready)
  );

  verdict_dispatch u_disp (
    .CLK           (CLK),
    .RST_N         (RST_N),
    .verdict_valid (verdict_valid),
    .verdict_pass  (verdict_pass),
    .verdict_ready (verdict_ready),
    .frames_ready  (frames_ready),
    .head_len      (head_len),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .slot_release  (slot_release),
    .tx_valid      (tx_valid),
    .tx_data       (tx_data),
    .tx_last       (tx_last),
    .tx_ready      (tx_ready),
    .drop_pulse    (drop_pulse)
  );

endmodule

// File: rtl/pd_pkg.sv
package pd_pkg;

  // ------------------------------
  // Base sizes
  // ------------------------------

  // Bits per stream byte
  localparam int BYTE_W     = 8;
  // Header bytes handed to the firewall
  localparam int HDR_LEN    = 20;
  // Frame slots in the store ring
  localparam int NUM_SLOTS  = 2;
  // Bytes per slot, also the longest frame
  localparam int SLOT_DEPTH = 64;

  // ------------------------------
  // Derived widths
  // ------------------------------

  localparam int HDR_W      = HDR_LEN * BYTE_W;
  localparam int SLOT_IDX_W = $clog2(NUM_SLOTS);
  localparam int ADDR_W     = $clog2(SLOT_DEPTH);
  // Length runs 1..SLOT_DEPTH, so one extra bit
  localparam int LEN_W      = $clog2(SLOT_DEPTH + 1);
  // Header byte counter saturates at HDR_LEN
  localparam int HDR_CNT_W  = $clog2(HDR_LEN + 1);
  // Occupied slot count runs 0..NUM_SLOTS
  localparam int SLOT_CNT_W = $clog2(NUM_SLOTS + 1);

  // ------------------------------
  // Vector types
  // ------------------------------

  typedef logic [BYTE_W-1:0]     byte_t;
  // First frame byte sits in the top byte
  typedef logic [HDR_W-1:0]      hdr_t;
  typedef logic [SLOT_IDX_W-1:0] slot_idx_t;
  typedef logic [ADDR_W-1:0]     byte_addr_t;
  typedef logic [LEN_W-1:0]      frame_len_t;
  typedef logic [HDR_CNT_W-1:0]  hdr_cnt_t;
  typedef logic [SLOT_CNT_W-1:0] slot_cnt_t;

endpackage

// File: rtl/pkt_store.sv
module pkt_store (
  input  logic               CLK,
  input  logic               RST_N,
  // Receive stream
  input  logic               rx_valid,
  input  pd_pkg::byte_t      rx_data,
  input  logic               rx_last,
  output logic               rx_ready,
  // Header side can take a new frame
  input  logic               hdr_room,
  // Read port on the oldest slot
  input  pd_pkg::byte_addr_t rd_addr,
  output pd_pkg::byte_t      rd_data,
  output pd_pkg::frame_len_t head_len,
  output logic               frames_ready,
  // Frees the oldest slot
  input  logic               slot_release
);

  import pd_pkg::*;

  // ------------------------------
  // Storage
  // ------------------------------

  // Frame bytes, one row per slot
  byte_t      mem [NUM_SLOTS][SLOT_DEPTH];
  // Stored length of each complete frame
  frame_len_t slot_len [NUM_SLOTS];

  // Ring pointers and fill level
  slot_idx_t  wr_slot;
  slot_idx_t  head_slot;
  slot_cnt_t  count;
  // Next byte position inside the write slot
  byte_addr_t wr_idx;

  logic       rx_fire;
  logic       wr_done;
  logic       in_frame;
  logic       slot_free;

  assign rx_fire   = rx_valid && rx_ready;
  assign wr_done   = rx_fire && rx_last;
  // Write index only leaves zero once a frame has started
  assign in_frame  = (wr_idx != '0);
  assign slot_free = (count < slot_cnt_t'(NUM_SLOTS));

  // New frames also wait for header room, a started frame does not
  assign rx_ready     = slot_free && (hdr_room || in_frame);
  assign frames_ready = (count != '0);

  // Oldest frame is read combinationally
  assign rd_data  = mem[head_slot][rd_addr];
  assign head_len = slot_len[head_slot];

  // ------------------------------
  // Write path
  // ------------------------------

  always_ff @(posedge CLK) begin
    if (rx_fire) begin
      mem[wr_slot][wr_idx] <= rx_data;
    end
    // Length is index plus one on the final byte
    if (wr_done) begin
      slot_len[wr_slot] <= frame_len_t'(wr_idx) + frame_len_t'(1);
    end
  end

  // ------------------------------
  // Ring control
  // ------------------------------

  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      wr_slot   <= '0;
      head_slot <= '0;
      count     <= '0;
      wr_idx    <= '0;
    end else begin
      if (rx_fire) begin
        if (rx_last) begin
          wr_idx  <= '0;
          // Two slots, so the pointer just toggles
          wr_slot <= wr_slot + slot_idx_t'(1);
        end else begin
          wr_idx  <= wr_idx + byte_addr_t'(1);
        end
      end
      if (slot_release) begin
        head_slot <= head_slot + slot_idx_t'(1);
      end
      // Completion and release may land on the same edge
      case ({wr_done, slot_release})
        2'b10:   count <= count + slot_cnt_t'(1);
        2'b01:   count <= count - slot_cnt_t'(1);
        default: count <= count;
      endcase
    end
  end

  // Dispatcher only frees a slot that holds a frame
  a_release_nonempty: assert property (
    @(posedge CLK) disable iff (!RST_N)
    slot_release |-> (count != '0)
  );

  // Source keeps frames within one slot
  a_frame_fits: assert property (
    @(posedge CLK) disable iff (!RST_N)
    (rx_fire && (wr_idx == byte_addr_t'(SLOT_DEPTH - 1))) |-> rx_last
  );

endmodule

// File: rtl/verdict_dispatch.sv
module verdict_dispatch (
  input  logic               CLK,
  input  logic               RST_N,
  // Verdict port
  input  logic               verdict_valid,
  input  logic               verdict_pass,
  output logic               verdict_ready,
  // Store status
  input  logic               frames_ready,
  input  pd_pkg::frame_len_t head_len,
  // Store read port and slot release
  output pd_pkg::byte_addr_t rd_addr,
  input  pd_pkg::byte_t      rd_data,
  output logic               slot_release,
  // Transmit stream
  output logic               tx_valid,
  output pd_pkg::byte_t      tx_data,
  output logic               tx_last,
  input  logic               tx_ready,
  output logic               drop_pulse
);

  import pd_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEND,
    ST_DROP
  } state_t;

  state_t     state;
  // Byte position of the oldest frame being sent
  byte_addr_t rd_cnt;
  logic       verdict_fire;
  logic       tx_fire;
  logic       at_end;

  assign verdict_fire = verdict_valid && verdict_ready;
  assign tx_fire      = tx_valid && tx_ready;
  // Final byte sits at length minus one
  assign at_end       = (frame_len_t'(rd_cnt) == (head_len - frame_len_t'(1)));

  // ------------------------------
  // Outputs
  // ------------------------------

  // Verdict only taken when its frame is fully stored
  assign verdict_ready = (state == ST_IDLE) && frames_ready;

  assign rd_addr  = rd_cnt;
  assign tx_data  = rd_data;
  assign tx_valid = (state == ST_SEND);
  assign tx_last  = (state == ST_SEND) && at_end;

  // Drop frees at once, a pass frees with its last byte
  assign drop_pulse   = (state == ST_DROP);
  assign slot_release = (state == ST_DROP) || (tx_fire && tx_last);

  // ------------------------------
  // FSM
  // ------------------------------

  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      state  <= ST_IDLE;
      rd_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          rd_cnt <= '0;
          if (verdict_fire) begin
            state <= verdict_pass ? ST_SEND : ST_DROP;
          end
        end
        ST_SEND: begin
          if (tx_fire) begin
            if (tx_last) begin
              state  <= ST_IDLE;
              rd_cnt <= '0;
            end else begin
              rd_cnt <= rd_cnt + byte_addr_t'(1);
            end
          end
        end
        ST_DROP: begin
          // Single cycle, slot freed here
          state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Byte held under sink back-pressure, store must not disturb the head slot
  a_tx_stable: assert property (
    @(posedge CLK) disable iff (!RST_N)
    (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data) && $stable(tx_last))
  );

  // Idle without a verdict stays idle, so no slot is freed next
  a_no_idle_release: assert property (
    @(posedge CLK) disable iff (!RST_N)
    ((state == ST_IDLE) && !verdict_fire) |=> !slot_release
  );

endmodule

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -j 0 --top-module tb_packet_dealer -f list.f \
  && out=$(./obj_dir/Vtb_packet_dealer) \
  && echo "$out" \
  && echo "$out" | grep -q "^TEST OK$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
